/* hdl/host_proto_pkg.sv */
// wire-format constants, opcode enum and response status enum
package host_proto_pkg;

    // frame markers on the byte streams
    localparam logic [7:0] rx_frame_id = 8'hCD;
    localparam logic [7:0] tx_frame_id = 8'hDC;

    // header field widths
    localparam int dword_width = 32;
    localparam int count_width = 24;

    // header bits 27..24
    typedef enum logic [3:0] {
        op_ping  = 4'h0,
        op_write = 4'h1,
        op_read  = 4'h2,
        op_reset = 4'h3
    } host_opcode_e;

    // low nibble of the response status byte
    typedef enum logic [3:0] {
        st_ping  = 4'hF,
        st_reset = 4'hC,
        st_read  = 4'hE,
        st_write = 4'hD
    } rsp_status_e;

endpackage

/* hdl/host_bus_pkg.sv */
// packed records for the byte streams, dword links and master-side beats
package host_bus_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic       first;
    } rx_byte_t;

    typedef struct packed {
        logic [host_proto_pkg::dword_width-1:0] word;
        logic                                   frame_start;
    } rx_dword_t;

    typedef struct packed {
        host_proto_pkg::host_opcode_e           opcode;
        logic [3:0]                             flags;
        logic [host_proto_pkg::count_width-1:0] count;
        logic [host_proto_pkg::dword_width-1:0] address;
        logic [host_proto_pkg::dword_width-1:0] data;
    } host_cmd_t;

    typedef struct packed {
        logic [7:0]                             status;
        logic [host_proto_pkg::count_width-1:0] count;
        logic [host_proto_pkg::dword_width-1:0] address;
        logic [host_proto_pkg::dword_width-1:0] data;
    } host_rsp_t;

    typedef struct packed {
        logic [host_proto_pkg::dword_width-1:0] word;
        logic                                   byte_only;
    } tx_word_t;

endpackage

/* hdl/dword_assembler.sv */
// frame hunter and big-endian byte to dword packer with holding register
module dword_assembler (
    input  logic                   clk,
    input  logic                   rst,
    input  host_bus_pkg::rx_byte_t rx,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    output host_bus_pkg::rx_dword_t dw,
    output logic                   dw_valid,
    input  logic                   dw_ready
);

    logic                                   in_frame;
    logic                                   start_pending;
    logic [1:0]                             byte_cnt;
    logic [host_proto_pkg::dword_width-9:0] shift_q;
    logic                                   rx_take;
    logic                                   word_done;

    // only a completing byte has to wait for the holding register
    assign rx_ready  = !(dw_valid && in_frame && !rx.first && byte_cnt == 2'd3);
    assign rx_take   = rx_valid && rx_ready;
    assign word_done = rx_take && !rx.first && in_frame && byte_cnt == 2'd3;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame      <= 1'b0;
            start_pending <= 1'b0;
            byte_cnt      <= 2'd0;
            dw_valid      <= 1'b0;
        end else begin
            if (dw_valid && dw_ready) begin
                dw_valid <= 1'b0;
            end
            if (rx_take) begin
                if (rx.first) begin
                    // any marker restarts the count, a bad one goes back to hunting
                    byte_cnt      <= 2'd0;
                    in_frame      <= (rx.data == host_proto_pkg::rx_frame_id);
                    start_pending <= (rx.data == host_proto_pkg::rx_frame_id);
                end else if (in_frame) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            if (word_done) begin
                dw_valid      <= 1'b1;
                start_pending <= 1'b0;
            end
        end
    end

    // shift register and holding register carry payload only
    always_ff @(posedge clk) begin
        if (rx_take && !rx.first && in_frame) begin
            shift_q <= {shift_q[15:0], rx.data};
        end
        if (word_done) begin
            dw.word        <= {shift_q, rx.data};
            dw.frame_start <= start_pending;
        end
    end

endmodule

/* hdl/command_parser.sv */
// inbound frame FSM producing master command beats and the reset pulse
module command_parser (
    input  logic                    clk,
    input  logic                    rst,
    input  host_bus_pkg::rx_dword_t dw,
    input  logic                    dw_valid,
    output logic                    dw_ready,
    output host_bus_pkg::host_cmd_t cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output logic                    cmd_reset
);

    typedef enum logic [1:0] {
        wait_header,
        wait_address,
        wait_data,
        deliver
    } state_e;

    state_e                                 state;
    host_bus_pkg::host_cmd_t                cmd_q;
    logic [host_proto_pkg::count_width-1:0] remain_q;
    logic [host_proto_pkg::count_width-1:0] hdr_count;
    host_proto_pkg::host_opcode_e           hdr_op;
    logic                                   take;
    logic                                   hdr_take;
    logic                                   addr_take;
    logic                                   data_take;

    assign dw_ready  = (state != deliver);
    assign cmd_valid = (state == deliver);
    assign cmd       = cmd_q;

    assign hdr_op    = host_proto_pkg::host_opcode_e'(dw.word[27:24]);
    assign hdr_count = dw.word[23:0];

    // a frame start always restarts decoding, other words only count inside a frame
    assign take      = dw_valid && dw_ready;
    assign hdr_take  = take && dw.frame_start;
    assign addr_take = take && !dw.frame_start && state == wait_address;
    assign data_take = take && !dw.frame_start && state == wait_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= wait_header;
            remain_q  <= '0;
            cmd_reset <= 1'b0;
        end else begin
            cmd_reset <= 1'b0;
            if (hdr_take) begin
                case (hdr_op)
                    host_proto_pkg::op_ping: begin
                        state <= deliver;
                    end
                    host_proto_pkg::op_write, host_proto_pkg::op_read: begin
                        state <= wait_address;
                        // a zero count still carries one data word
                        remain_q <= hdr_count |
                            {{(host_proto_pkg::count_width - 1){1'b0}}, hdr_count == '0};
                    end
                    host_proto_pkg::op_reset: begin
                        cmd_reset <= 1'b1;
                        state     <= wait_header;
                    end
                    default: begin
                        // rest of the frame is dropped in wait_header
                        state <= wait_header;
                    end
                endcase
            end else if (addr_take) begin
                state <= (cmd_q.opcode == host_proto_pkg::op_write) ? wait_data : deliver;
            end else if (data_take) begin
                remain_q <= remain_q - 1'b1;
                state    <= deliver;
            end else if (cmd_valid && cmd_ready) begin
                if (cmd_q.opcode == host_proto_pkg::op_write && remain_q != '0) begin
                    state <= wait_data;
                end else begin
                    state <= wait_header;
                end
            end
        end
    end

    // beat payload, address stays put across the data words of a write
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            cmd_q.opcode  <= hdr_op;
            cmd_q.flags   <= dw.word[31:28];
            cmd_q.count   <= hdr_count;
            cmd_q.address <= '0;
            cmd_q.data    <= '0;
        end else if (addr_take) begin
            cmd_q.address <= dw.word;
        end else if (data_take) begin
            cmd_q.data <= dw.word;
        end
    end

endmodule

/* hdl/response_framer.sv */
// outbound FSM turning response beats into ID, status, address and data words
module response_framer (
    input  logic                    clk,
    input  logic                    rst,
    input  host_bus_pkg::host_rsp_t rsp,
    input  logic                    rsp_valid,
    output logic                    rsp_ready,
    output host_bus_pkg::tx_word_t  tw,
    output logic                    tw_valid,
    input  logic                    tw_ready
);

    typedef enum logic [2:0] {
        idle,
        send_id,
        send_status,
        send_address,
        send_data,
        more_data
    } state_e;

    state_e                                 state;
    host_bus_pkg::host_rsp_t                rsp_q;
    logic [host_proto_pkg::count_width-1:0] remain_q;
    logic                                   rsp_take;
    logic                                   tw_done;
    logic                                   is_write;
    logic                                   has_body;

    assign rsp_take = rsp_valid && rsp_ready;
    assign tw_done  = tw_valid && tw_ready;
    assign is_write = (rsp_q.status[3:0] == host_proto_pkg::st_write);
    assign has_body = is_write || (rsp_q.status[3:0] == host_proto_pkg::st_read);

    // word presented to the serializer for the current state
    always_comb begin
        tw_valid     = 1'b1;
        tw.byte_only = 1'b0;
        tw.word      = '0;
        case (state)
            send_id: begin
                tw.word      = {host_proto_pkg::tx_frame_id,
                                {host_proto_pkg::count_width{1'b0}}};
                tw.byte_only = 1'b1;
            end
            send_status: begin
                if (has_body) begin
                    tw.word = {rsp_q.status, rsp_q.count};
                end else begin
                    tw.word = {rsp_q.status, {host_proto_pkg::count_width{1'b0}}};
                end
            end
            send_address: begin
                tw.word = rsp_q.address;
            end
            send_data: begin
                tw.word = rsp_q.data;
            end
            default: begin
                tw_valid = 1'b0;
            end
        endcase
    end

    // rsp_ready is registered and high only while sitting in idle or more_data
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            rsp_ready <= 1'b0;
            remain_q  <= '0;
        end else begin
            rsp_ready <= 1'b0;
            case (state)
                idle: begin
                    if (rsp_take) begin
                        state    <= send_id;
                        remain_q <= rsp.count;
                    end else begin
                        rsp_ready <= 1'b1;
                    end
                end
                send_id: begin
                    if (tw_done) begin
                        state <= send_status;
                    end
                end
                send_status: begin
                    if (tw_done) begin
                        if (has_body) begin
                            state <= send_address;
                        end else begin
                            state     <= idle;
                            rsp_ready <= 1'b1;
                        end
                    end
                end
                send_address: begin
                    if (tw_done) begin
                        state <= send_data;
                    end
                end
                send_data: begin
                    if (tw_done) begin
                        state     <= (is_write && remain_q != '0) ? more_data : idle;
                        rsp_ready <= 1'b1;
                    end
                end
                more_data: begin
                    if (rsp_take) begin
                        state    <= send_data;
                        remain_q <= remain_q - 1'b1;
                    end else begin
                        rsp_ready <= 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // extra beats only replace the data word
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            if (state == idle) begin
                rsp_q <= rsp;
            end else begin
                rsp_q.data <= rsp.data;
            end
        end
    end

endmodule

/* hdl/dword_serializer.sv */
// word to byte shifter, MSB first, towards the transmit stream
module dword_serializer (
    input  logic                   clk,
    input  logic                   rst,
    input  host_bus_pkg::tx_word_t tw,
    input  logic                   tw_valid,
    output logic                   tw_ready,
    output logic [7:0]             tx,
    output logic                   tx_valid,
    input  logic                   tx_ready
);

    logic [host_proto_pkg::dword_width-1:0] shift_q;
    // bytes still to send, 0 means empty
    logic [2:0]                             left_q;
    logic                                   load;
    logic                                   tx_take;

    assign tw_ready = (left_q == 3'd0);
    assign tx_valid = (left_q != 3'd0);
    assign tx       = shift_q[31:24];
    assign load     = tw_valid && tw_ready;
    assign tx_take  = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            left_q <= 3'd0;
        end else if (load) begin
            left_q <= tw.byte_only ? 3'd1 : 3'd4;
        end else if (tx_take) begin
            left_q <= left_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tw.word;
        end else if (tx_take) begin
            shift_q <= {shift_q[23:0], 8'h00};
        end
    end

endmodule

/* hdl/host_interface.sv */
// host protocol engine top: inbound assembler and parser, outbound framer and serializer
module host_interface (
    input  logic                    clk,
    input  logic                    rst,
    input  host_bus_pkg::rx_byte_t  rx,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    output host_bus_pkg::host_cmd_t cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output logic                    cmd_reset,
    input  host_bus_pkg::host_rsp_t rsp,
    input  logic                    rsp_valid,
    output logic                    rsp_ready,
    output logic [7:0]              tx,
    output logic                    tx_valid,
    input  logic                    tx_ready
);

    // assembler to parser
    host_bus_pkg::rx_dword_t dw;
    logic                    dw_valid;
    logic                    dw_ready;

    // framer to serializer
    host_bus_pkg::tx_word_t  tw;
    logic                    tw_valid;
    logic                    tw_ready;

    dword_assembler dword_assembler_inst (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .dw       (dw),
        .dw_valid (dw_valid),
        .dw_ready (dw_ready)
    );

    command_parser command_parser_inst (
        .clk       (clk),
        .rst       (rst),
        .dw        (dw),
        .dw_valid  (dw_valid),
        .dw_ready  (dw_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_reset (cmd_reset)
    );

    response_framer response_framer_inst (
        .clk       (clk),
        .rst       (rst),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .tw        (tw),
        .tw_valid  (tw_valid),
        .tw_ready  (tw_ready)
    );

    dword_serializer dword_serializer_inst (
        .clk      (clk),
        .rst      (rst),
        .tw       (tw),
        .tw_valid (tw_valid),
        .tw_ready (tw_ready),
        .tx       (tx),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

endmodule

/* test/host_interface_asserts.sv */
// handshake stability, reset pulse and reset state assertions bound to the top level
module host_interface_asserts (
    input logic                    clk,
    input logic                    rst,
    input host_bus_pkg::host_cmd_t cmd,
    input logic                    cmd_valid,
    input logic                    cmd_ready,
    input logic                    cmd_reset,
    input logic [7:0]              tx,
    input logic                    tx_valid,
    input logic                    tx_ready,
    input logic                    rsp_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("cmd beat changed before its transfer");

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx))
        else $error("tx byte changed before its transfer");

    reset_pulse: assert property (@(posedge clk) disable iff (rst)
        cmd_reset |=> !cmd_reset)
        else $error("cmd_reset lasted two cycles");

    // valid outputs are cleared by the reset edge
    reset_quiet: assert property (@(posedge clk)
        rst |=> !cmd_valid && !cmd_reset && !tx_valid && !rsp_ready)
        else $error("output active during or right after reset");

endmodule

bind host_interface host_interface_asserts host_interface_asserts_inst (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_reset (cmd_reset),
    .tx        (tx),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rsp_ready (rsp_ready)
);

/* test/tb_host_interface.sv */
// host protocol engine testbench with stimulus, reference model, checks and report
module tb_host_interface;
    timeunit 1ns;
    timeprecision 1ps;

    typedef host_bus_pkg::rx_byte_t  byte_q_t[$];
    typedef host_bus_pkg::host_cmd_t cmd_q_t[$];
    typedef logic [7:0]              tx_q_t[$];
    typedef logic [31:0]             word_q_t[$];

    logic                    clk;
    logic                    rst;
    host_bus_pkg::rx_byte_t  rx;
    logic                    rx_valid;
    logic                    rx_ready;
    host_bus_pkg::host_cmd_t cmd;
    logic                    cmd_valid;
    logic                    cmd_ready;
    logic                    cmd_reset;
    host_bus_pkg::host_rsp_t rsp;
    logic                    rsp_valid;
    logic                    rsp_ready;
    logic [7:0]              tx;
    logic                    tx_valid;
    logic                    tx_ready;

    // outputs still owed by the DUT in the running test
    cmd_q_t exp_cmds;
    tx_q_t  exp_bytes;
    int     exp_resets = 0;
    int     test_errors = 0;
    int     total_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    host_interface host_interface_inst (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_reset (cmd_reset),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .tx        (tx),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back pressure from the master and from the transmit side
    always @(posedge clk) begin
        cmd_ready <= ($urandom % 4) != 0;
        tx_ready  <= ($urandom % 3) != 0;
    end

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_cmd(input host_bus_pkg::host_cmd_t got);
        host_bus_pkg::host_cmd_t exp;
        if (exp_cmds.size() == 0) begin
            $display("unexpected command beat %h", got);
            count_error();
        end else begin
            exp = exp_cmds.pop_front();
            if (got !== exp) begin
                $display("FAILED cmd: got %h expected %h", got, exp);
                count_error();
            end
        end
    endtask

    task automatic check_byte(input logic [7:0] got);
        logic [7:0] exp;
        if (exp_bytes.size() == 0) begin
            $display("unexpected tx byte %h", got);
            count_error();
        end else begin
            exp = exp_bytes.pop_front();
            if (got !== exp) begin
                $display("FAILED tx: got %h expected %h", got, exp);
                count_error();
            end
        end
    endtask

    task automatic check_reset(input logic pulse);
        if (pulse) begin
            if (exp_resets == 0) begin
                $display("cmd_reset pulsed although no reset command was sent");
                count_error();
            end else begin
                exp_resets--;
            end
        end
    endtask

    // compares every transfer as it happens
    always @(posedge clk) begin
        if (!rst) begin
            if (cmd_valid && cmd_ready) begin
                check_cmd(cmd);
            end
            if (tx_valid && tx_ready) begin
                check_byte(tx);
            end
            check_reset(cmd_reset);
        end
    end

    // beats and reset pulses that a byte stream should produce
    function automatic void expected_cmds(input byte_q_t bytes, inout cmd_q_t cmds,
                                          inout int resets);
        logic                    in_frame;
        logic                    start;
        int                      cnt;
        logic [31:0]             word;
        int                      phase;
        int                      remain;
        host_bus_pkg::host_cmd_t c;
        in_frame = 1'b0;
        start = 1'b0;
        cnt = 0;
        word = '0;
        // phase 0 header, 1 address, 2 write data
        phase = 0;
        remain = 0;
        c = '0;
        foreach (bytes[i]) begin
            if (bytes[i].first) begin
                in_frame = (bytes[i].data == host_proto_pkg::rx_frame_id);
                start = in_frame;
                cnt = 0;
            end else if (in_frame) begin
                word = {word[23:0], bytes[i].data};
                cnt++;
                if (cnt == 4) begin
                    cnt = 0;
                    if (start) begin
                        c = '0;
                        c.opcode = host_proto_pkg::host_opcode_e'(word[27:24]);
                        c.flags = word[31:28];
                        c.count = word[23:0];
                        remain = (word[23:0] == 24'h0) ? 1 : int'(word[23:0]);
                        phase = 0;
                        case (c.opcode)
                            host_proto_pkg::op_ping: cmds.push_back(c);
                            host_proto_pkg::op_write: phase = 1;
                            host_proto_pkg::op_read: phase = 1;
                            host_proto_pkg::op_reset: resets++;
                            default: phase = 0;
                        endcase
                    end else if (phase == 1) begin
                        c.address = word;
                        if (c.opcode == host_proto_pkg::op_read) begin
                            cmds.push_back(c);
                            phase = 0;
                        end else begin
                            phase = 2;
                        end
                    end else if (phase == 2) begin
                        c.data = word;
                        cmds.push_back(c);
                        remain--;
                        if (remain == 0) begin
                            phase = 0;
                        end
                    end
                    start = 1'b0;
                end
            end
        end
    endfunction

    // ID byte and status dword, then address and data for read and write status
    function automatic void expected_bytes(input host_bus_pkg::host_rsp_t r,
                                           input word_q_t extra, inout tx_q_t bytes);
        word_q_t words;
        logic    is_write;
        is_write = (r.status[3:0] == host_proto_pkg::st_write);
        bytes.push_back(host_proto_pkg::tx_frame_id);
        if (is_write || r.status[3:0] == host_proto_pkg::st_read) begin
            words.push_back({r.status, r.count});
            words.push_back(r.address);
            words.push_back(r.data);
            if (is_write) begin
                for (int i = 0; i < int'(r.count); i++) begin
                    words.push_back(extra[i]);
                end
            end
        end else begin
            words.push_back({r.status, 24'h0});
        end
        foreach (words[i]) begin
            for (int k = 3; k >= 0; k--) begin
                bytes.push_back(words[i][8*k +: 8]);
            end
        end
    endfunction

    function automatic void add_byte(inout byte_q_t s, input logic first, input logic [7:0] data);
        host_bus_pkg::rx_byte_t b;
        b.first = first;
        b.data = data;
        s.push_back(b);
    endfunction

    // appends the frame marker and n dwords MSB first
    function automatic void add_frame(inout byte_q_t s, input int n, input logic [31:0] w0,
                                      input logic [31:0] w1 = '0, input logic [31:0] w2 = '0,
                                      input logic [31:0] w3 = '0, input logic [31:0] w4 = '0);
        logic [31:0] w[5];
        w = '{w0, w1, w2, w3, w4};
        add_byte(s, 1'b1, host_proto_pkg::rx_frame_id);
        for (int i = 0; i < n; i++) begin
            for (int k = 3; k >= 0; k--) begin
                add_byte(s, 1'b0, w[i][8*k +: 8]);
            end
        end
    endfunction

    task automatic send_bytes(input byte_q_t bytes);
        int t;
        foreach (bytes[i]) begin
            repeat ($urandom % 3) begin
                rx_valid <= 1'b0;
                @(posedge clk);
            end
            rx <= bytes[i];
            rx_valid <= 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!rx_ready && t < 1000);
            if (!rx_ready) begin
                $display("rx_ready stayed low for 1000 cycles on byte %0d", i);
                count_error();
            end
        end
        rx_valid <= 1'b0;
    endtask

    task automatic send_rsp(input host_bus_pkg::host_rsp_t r, input word_q_t extra);
        host_bus_pkg::host_rsp_t beat;
        int                      t;
        beat = r;
        expected_bytes(r, extra, exp_bytes);
        for (int i = 0; i <= extra.size(); i++) begin
            if (i > 0) begin
                beat.data = extra[i-1];
            end
            rsp <= beat;
            rsp_valid <= 1'b1;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!rsp_ready && t < 1000);
            if (!rsp_ready) begin
                $display("rsp_ready stayed low for 1000 cycles on beat %0d", i);
                count_error();
            end
        end
        rsp_valid <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        int t;
        t = 0;
        while ((exp_cmds.size() != 0 || exp_bytes.size() != 0 || exp_resets != 0)
               && t < 3000) begin
            @(negedge clk);
            t++;
        end
        if (exp_cmds.size() != 0 || exp_bytes.size() != 0 || exp_resets != 0) begin
            $display("timeout in %s: %0d beats, %0d bytes and %0d reset pulses never came",
                     name, exp_cmds.size(), exp_bytes.size(), exp_resets);
            count_error();
            exp_cmds.delete();
            exp_bytes.delete();
            exp_resets = 0;
        end
        // quiet window so that stray outputs are caught in this test
        repeat (40) @(posedge clk);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end else begin
            $display("test %s: ok", name);
        end
        test_errors = 0;
    endtask

    task automatic run_inbound(input string name, input byte_q_t s);
        expected_cmds(s, exp_cmds, exp_resets);
        send_bytes(s);
        finish_test(name);
    endtask

    initial begin
        byte_q_t                 s;
        word_q_t                 none;
        word_q_t                 extra;
        host_bus_pkg::host_rsp_t r;
        void'($urandom(61));
        rst = 1'b1;
        rx = '0;
        rx_valid = 1'b0;
        cmd_ready = 1'b0;
        rsp = '0;
        rsp_valid = 1'b0;
        tx_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        add_frame(s, 1, 32'h5000_0123);
        run_inbound("ping", s);

        s.delete();
        add_frame(s, 5, 32'h0100_0003, 32'h2000_0040, $urandom, $urandom, $urandom);
        add_frame(s, 2, 32'h9200_0000, 32'h0000_0A5C);
        run_inbound("write and read", s);

        s.delete();
        add_byte(s, 1'b0, 8'h11);
        add_byte(s, 1'b0, 8'h22);
        add_byte(s, 1'b0, 8'h33);
        add_frame(s, 0, 32'h0);
        s[3].data = 8'hAB;
        // a ping header behind the bad marker
        add_byte(s, 1'b0, 8'h40);
        add_byte(s, 1'b0, 8'h00);
        add_byte(s, 1'b0, 8'h00);
        add_byte(s, 1'b0, 8'h02);
        add_frame(s, 1, 32'h0000_00FF);
        run_inbound("garbage then ping", s);

        s.delete();
        add_frame(s, 1, 32'h0300_0000);
        add_frame(s, 2, 32'h0700_0001, 32'hDEAD_BEEF);
        add_frame(s, 1, 32'hA000_0007);
        run_inbound("reset and unknown opcode", s);

        r = '{status: 8'h0F, count: 24'h000005, address: 32'h1111_2222, data: 32'h3333_4444};
        send_rsp(r, none);
        r.status = 8'h0C;
        send_rsp(r, none);
        r = '{status: 8'h0E, count: 24'h000001, address: 32'h0000_0A5C, data: $urandom};
        send_rsp(r, none);
        finish_test("ping, reset and read responses");

        extra.push_back($urandom);
        extra.push_back($urandom);
        r = '{status: 8'h0D, count: 24'h000002, address: 32'h2000_0040, data: $urandom};
        send_rsp(r, extra);
        finish_test("write response with two extra beats");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/host_proto_pkg.sv
hdl/host_bus_pkg.sv
hdl/dword_assembler.sv
hdl/command_parser.sv
hdl/response_framer.sv
hdl/dword_serializer.sv
hdl/host_interface.sv
test/host_interface_asserts.sv
test/tb_host_interface.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the failure message in the log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_host_interface -f list.f \
    -o tb_host_interface > build.log 2>&1 \
    && ./obj_dir/tb_host_interface > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
